// File: source/translator_pkg.sv
// width constants and vector typedefs shared by the slave translator

`default_nettype none

package translator_pkg;

   // --------------------------------------------------
   // data and address widths
   // --------------------------------------------------

   // same data width on the request and slave sides
   localparam int DATA_W = 32;

   // symbols (bytes) per data word
   localparam int BYTES_PER_WORD = 4;

   // log2 of BYTES_PER_WORD, byte to word address shift
   localparam int WORD_SHIFT = 2;

   localparam int BYTE_ADDR_W = 32;
   localparam int WORD_ADDR_W = BYTE_ADDR_W - WORD_SHIFT;

   // wait counter width
   // setup + write wait + hold and setup + read wait must fit, i.e. stay at or below 15
   localparam int WAIT_COUNT_W = 4;

   // --------------------------------------------------
   // vector types
   // --------------------------------------------------

   typedef logic [DATA_W-1:0] data_t;

   typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;

   typedef logic [WORD_ADDR_W-1:0] word_addr_t;

   typedef logic [BYTES_PER_WORD-1:0] byteen_t;

   typedef logic [WAIT_COUNT_W-1:0] wait_count_t;

endpackage

`default_nettype wire

// File: source/request_adapter.sv
// request_adapter: word address, byte enables and begin-transfer pulse

`timescale 1ns/1ns
`default_nettype none

module request_adapter (
   input  wire logic                    clk,
   input  wire logic                    reset,

   // request side
   input  wire translator_pkg::byte_addr_t uav_address,
   input  wire translator_pkg::data_t      uav_writedata,
   input  wire translator_pkg::byteen_t    uav_byteenable,
   input  wire logic                    uav_read,
   input  wire logic                    uav_write,

   // generated waitrequest from the wait-state generator
   input  wire logic                    waitrequest,

   // slave side
   output translator_pkg::word_addr_t   av_address,
   output translator_pkg::data_t        av_writedata,
   output translator_pkg::byteen_t      av_byteenable,
   output translator_pkg::byteen_t      av_writebyteenable,
   output logic                         av_begintransfer
);

   logic request;
   logic begun;

   // --------------------------------------------------
   // address, data and byte enables
   // --------------------------------------------------

   // drop the byte offset bits to get the word address
   assign av_address =
      uav_address[translator_pkg::BYTE_ADDR_W-1:translator_pkg::WORD_SHIFT];

   assign av_writedata  = uav_writedata;
   assign av_byteenable = uav_byteenable;

   // write byte enables only during a write
   assign av_writebyteenable =
      {translator_pkg::BYTES_PER_WORD{uav_write}} & uav_byteenable;

   // --------------------------------------------------
   // begin-transfer
   // --------------------------------------------------

   assign request = uav_read | uav_write;

   // first cycle of an access only
   assign av_begintransfer = request & ~begun;

   // set once the access has started and is still waiting,
   // cleared on the accept cycle so the next access pulses again
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         begun <= 1'b0;
      end else if (!waitrequest) begin
         begun <= 1'b0;
      end else if (av_begintransfer) begin
         begun <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: source/wait_state_generator.sv
// wait_state_generator: cycle counter, gated slave strobes, generated waitrequest

`timescale 1ns/1ns
`default_nettype none

module wait_state_generator #(
   parameter int SETUP_CYCLES      = 1,
   parameter int READ_WAIT_CYCLES  = 2,
   parameter int WRITE_WAIT_CYCLES = 1,
   parameter int HOLD_CYCLES       = 1
) (
   input  wire logic clk,
   input  wire logic reset,

   input  wire logic uav_read,
   input  wire logic uav_write,

   output logic      av_read,
   output logic      av_write,
   output logic      waitrequest
);

   // --------------------------------------------------
   // count boundaries
   // --------------------------------------------------

   // first count with the slave strobe asserted
   localparam translator_pkg::wait_count_t STROBE_START =
      translator_pkg::wait_count_t'(SETUP_CYCLES);

   // last count with av_write asserted
   localparam translator_pkg::wait_count_t WRITE_STROBE_END =
      translator_pkg::wait_count_t'(SETUP_CYCLES + WRITE_WAIT_CYCLES);

   // accept counts
   localparam translator_pkg::wait_count_t READ_ACCEPT =
      translator_pkg::wait_count_t'(SETUP_CYCLES + READ_WAIT_CYCLES);
   localparam translator_pkg::wait_count_t WRITE_ACCEPT =
      translator_pkg::wait_count_t'(SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES);

   translator_pkg::wait_count_t wait_count;
   logic                        reset_override;
   logic                        request;
   logic                        wait_generated;

   assign request = uav_read | uav_write;

   // --------------------------------------------------
   // cycle counter
   // --------------------------------------------------

   // holds waitrequest high for the first cycle out of reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
      end
   end

   // counts the cycles of the current access, back to zero after accept
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_count <= '0;
      end else if (!waitrequest || reset_override) begin
         wait_count <= '0;
      end else if (request) begin
         wait_count <= wait_count + 1'b1;
      end else begin
         wait_count <= '0;
      end
   end

   // --------------------------------------------------
   // strobes and waitrequest
   // --------------------------------------------------

   assign av_read  = uav_read & (wait_count >= STROBE_START);

   assign av_write = uav_write & (wait_count >= STROBE_START)
                     & (wait_count <= WRITE_STROBE_END);

   // write accept includes the data hold cycles
   always_comb begin
      if (uav_write) begin
         wait_generated = (wait_count != WRITE_ACCEPT);
      end else begin
         wait_generated = (wait_count != READ_ACCEPT);
      end
   end

   assign waitrequest = wait_generated | reset_override;

endmodule

`default_nettype wire

// File: source/read_latency_tracker.sv
// read_latency_tracker: fixed read-latency shift register, readdatavalid, read data select

`timescale 1ns/1ns
`default_nettype none

module read_latency_tracker #(
   parameter int READ_LATENCY = 2
) (
   input  wire logic                  clk,
   input  wire logic                  reset,

   input  wire logic                  uav_read,
   input  wire logic                  waitrequest,

   input  wire translator_pkg::data_t av_readdata,

   output translator_pkg::data_t      uav_readdata,
   output logic                       uav_readdatavalid
);

   // zero latency is stretched to one registered cycle
   localparam int DEPTH = (READ_LATENCY > 0) ? READ_LATENCY : 1;

   logic [DEPTH-1:0]      valid_shift;
   logic                  read_accept;
   translator_pkg::data_t readdata_q;

   // read accepted in this cycle
   assign read_accept = uav_read & ~waitrequest;

   // --------------------------------------------------
   // latency shift register
   // --------------------------------------------------

   // one bit per outstanding read cycle, several reads may be in flight
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid_shift <= '0;
      end else begin
         valid_shift[0] <= read_accept;
         for (int i = 1; i < DEPTH; i++) begin
            valid_shift[i] <= valid_shift[i-1];
         end
      end
   end

   assign uav_readdatavalid = valid_shift[DEPTH-1];

   // --------------------------------------------------
   // read data
   // --------------------------------------------------

   // slave data one cycle late, for the zero latency slave
   always_ff @(posedge clk) begin
      readdata_q <= av_readdata;
   end

   // a slave with latency gives valid data in the valid cycle itself
   assign uav_readdata = (READ_LATENCY == 0) ? readdata_q : av_readdata;

endmodule

`default_nettype wire

// File: source/slave_translator.sv
// slave_translator: top level connecting request adapter, wait states and read latency

`timescale 1ns/1ns
`default_nettype none

module slave_translator #(
   parameter int SETUP_CYCLES      = 1,
   parameter int READ_WAIT_CYCLES  = 2,
   parameter int WRITE_WAIT_CYCLES = 1,
   parameter int HOLD_CYCLES       = 1,
   parameter int READ_LATENCY      = 2
) (
   input  wire logic                       clk,
   input  wire logic                       reset,

   // --------------------------------------------------
   // request side
   // --------------------------------------------------
   input  wire translator_pkg::byte_addr_t uav_address,
   input  wire translator_pkg::data_t      uav_writedata,
   input  wire translator_pkg::byteen_t    uav_byteenable,
   input  wire logic                       uav_read,
   input  wire logic                       uav_write,
   output logic                            uav_waitrequest,
   output translator_pkg::data_t           uav_readdata,
   output logic                            uav_readdatavalid,

   // --------------------------------------------------
   // fixed-timing slave side
   // --------------------------------------------------
   output translator_pkg::word_addr_t      av_address,
   output translator_pkg::data_t           av_writedata,
   output translator_pkg::byteen_t         av_byteenable,
   output translator_pkg::byteen_t         av_writebyteenable,
   output logic                            av_begintransfer,
   output logic                            av_read,
   output logic                            av_write,
   input  wire translator_pkg::data_t      av_readdata
);

   // address, enables, begin-transfer
   request_adapter u_request_adapter (
      .clk                (clk),
      .reset              (reset),
      .uav_address        (uav_address),
      .uav_writedata      (uav_writedata),
      .uav_byteenable     (uav_byteenable),
      .uav_read           (uav_read),
      .uav_write          (uav_write),
      .waitrequest        (uav_waitrequest),
      .av_address         (av_address),
      .av_writedata       (av_writedata),
      .av_byteenable      (av_byteenable),
      .av_writebyteenable (av_writebyteenable),
      .av_begintransfer   (av_begintransfer)
   );

   // setup, wait and hold timing
   wait_state_generator #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES)
   ) u_wait_state_generator (
      .clk         (clk),
      .reset       (reset),
      .uav_read    (uav_read),
      .uav_write   (uav_write),
      .av_read     (av_read),
      .av_write    (av_write),
      .waitrequest (uav_waitrequest)
   );

   // readdatavalid after the fixed slave latency
   read_latency_tracker #(
      .READ_LATENCY (READ_LATENCY)
   ) u_read_latency_tracker (
      .clk               (clk),
      .reset             (reset),
      .uav_read          (uav_read),
      .waitrequest       (uav_waitrequest),
      .av_readdata       (av_readdata),
      .uav_readdata      (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid)
   );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// testbench clock and reset generator

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // reset rises just after time zero, released on a rising edge
   initial begin
      reset = 1'b0;
      #1;
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

// File: verif/slave_translator_tb.sv
// testbench: fixed-latency slave model, reference model, stimulus and assertions

`timescale 1ns/1ns
`default_nettype none

module slave_translator_tb;

   localparam int SETUP_CYCLES      = 1;
   localparam int READ_WAIT_CYCLES  = 2;
   localparam int WRITE_WAIT_CYCLES = 1;
   localparam int HOLD_CYCLES       = 1;
   localparam int READ_LATENCY      = 2;
   localparam int RESET_CYCLES      = 10;
   localparam int READ_ACCEPT       = SETUP_CYCLES + READ_WAIT_CYCLES;
   localparam int WRITE_ACCEPT      = SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES;
   localparam int VALID_DEPTH       = (READ_LATENCY > 0) ? READ_LATENCY : 1;
   localparam int MODEL_DEPTH       = (READ_LATENCY > 1) ? READ_LATENCY - 1 : 1;
   localparam int CYCLE_LIMIT       = 40 * 12 + RESET_CYCLES;

   logic                        clk;
   logic                        reset;
   translator_pkg::byte_addr_t  uav_address;
   translator_pkg::data_t       uav_writedata;
   translator_pkg::byteen_t     uav_byteenable;
   logic                        uav_read;
   logic                        uav_write;
   logic                        uav_waitrequest;
   translator_pkg::data_t       uav_readdata;
   logic                        uav_readdatavalid;
   translator_pkg::word_addr_t  av_address;
   translator_pkg::data_t       av_writedata;
   translator_pkg::byteen_t     av_byteenable;
   translator_pkg::byteen_t     av_writebyteenable;
   logic                        av_begintransfer;
   logic                        av_read;
   logic                        av_write;
   translator_pkg::data_t       av_readdata = '0;

   // slave model and reference state
   translator_pkg::data_t       slave_mem [translator_pkg::word_addr_t];
   translator_pkg::data_t       ref_mem [translator_pkg::word_addr_t];
   logic [MODEL_DEPTH-1:0]      slave_pipe_valid = '0;
   translator_pkg::word_addr_t  slave_pipe_addr [MODEL_DEPTH];
   logic                        request;
   translator_pkg::word_addr_t  req_word;
   int                          access_cycle;
   logic                        was_reset;
   logic [VALID_DEPTH-1:0]      exp_valid;
   translator_pkg::data_t       exp_data [VALID_DEPTH];
   logic [31:0]                 lfsr_state;
   translator_pkg::byte_addr_t  used_addr [8];
   int                          error_count;
   int                          test_count;
   int                          cycle_count;

   tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   slave_translator #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES),
      .READ_LATENCY      (READ_LATENCY)
   ) u_slave_translator (
      .clk                (clk),
      .reset              (reset),
      .uav_address        (uav_address),
      .uav_writedata      (uav_writedata),
      .uav_byteenable     (uav_byteenable),
      .uav_read           (uav_read),
      .uav_write          (uav_write),
      .uav_waitrequest    (uav_waitrequest),
      .uav_readdata       (uav_readdata),
      .uav_readdatavalid  (uav_readdatavalid),
      .av_address         (av_address),
      .av_writedata       (av_writedata),
      .av_byteenable      (av_byteenable),
      .av_writebyteenable (av_writebyteenable),
      .av_begintransfer   (av_begintransfer),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_readdata        (av_readdata)
   );

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------

   // unwritten words read back as a pattern of their address
   function automatic translator_pkg::data_t fill_word(input translator_pkg::word_addr_t addr);
      translator_pkg::data_t wide;
      wide = translator_pkg::data_t'(addr);
      return wide ^ (wide << 2) ^ 32'hc0de_5a3c;
   endfunction

   function automatic translator_pkg::data_t merge_bytes(input translator_pkg::data_t old_word,
         input translator_pkg::data_t new_word, input translator_pkg::byteen_t be);
      translator_pkg::data_t mask;
      for (int i = 0; i < translator_pkg::BYTES_PER_WORD; i++) begin
         mask[8*i +: 8] = {8{be[i]}};
      end
      return (old_word & ~mask) | (new_word & mask);
   endfunction

   function automatic translator_pkg::data_t slave_read(input translator_pkg::word_addr_t addr);
      if (slave_mem.exists(addr)) begin
         return slave_mem[addr];
      end
      return fill_word(addr);
   endfunction

   function automatic translator_pkg::data_t ref_read(input translator_pkg::word_addr_t addr);
      if (ref_mem.exists(addr)) begin
         return ref_mem[addr];
      end
      return fill_word(addr);
   endfunction

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         value = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      end
      return value;
   endfunction

   function automatic void report_mismatch(input string name, input logic [31:0] got,
         input logic [31:0] expected);
      $display("FAILED %s: got %h expected %h", name, got, expected);
      error_count++;
   endfunction

   // --------------------------------------------------
   // slave model and reference
   // --------------------------------------------------

   // fixed-latency slave, write data taken on every av_write cycle
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         slave_pipe_valid <= '0;
         av_readdata <= '0;
      end else begin
         if (av_write) begin
            slave_mem[av_address] = merge_bytes(slave_read(av_address), av_writedata,
                                                av_writebyteenable);
         end
         slave_pipe_valid[0] <= av_read & ~uav_waitrequest;
         slave_pipe_addr[0] <= av_address;
         for (int i = 1; i < MODEL_DEPTH; i++) begin
            slave_pipe_valid[i] <= slave_pipe_valid[i-1];
            slave_pipe_addr[i] <= slave_pipe_addr[i-1];
         end
         if (slave_pipe_valid[MODEL_DEPTH-1]) begin
            av_readdata <= slave_read(slave_pipe_addr[MODEL_DEPTH-1]);
         end
      end
   end

   assign request  = uav_read | uav_write;
   assign req_word = translator_pkg::word_addr_t'(uav_address >> translator_pkg::WORD_SHIFT);

   // cycle within the access and expected read returns
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         access_cycle <= 0;
         was_reset <= 1'b1;
         exp_valid <= '0;
      end else begin
         was_reset <= 1'b0;
         if (uav_write && access_cycle == WRITE_ACCEPT) begin
            ref_mem[req_word] = merge_bytes(ref_read(req_word), uav_writedata, uav_byteenable);
            access_cycle <= 0;
         end else if (uav_read && access_cycle == READ_ACCEPT) begin
            access_cycle <= 0;
         end else if (request) begin
            access_cycle <= access_cycle + 1;
         end else begin
            access_cycle <= 0;
         end
         exp_valid[0] <= uav_read && access_cycle == READ_ACCEPT;
         exp_data[0] <= ref_read(req_word);
         for (int i = 1; i < VALID_DEPTH; i++) begin
            exp_valid[i] <= exp_valid[i-1];
            exp_data[i] <= exp_data[i-1];
         end
      end
   end

   // --------------------------------------------------
   // assertions
   // --------------------------------------------------

   assert property (@(posedge clk) (reset || was_reset)
         |-> !(av_read || av_write || av_begintransfer || uav_readdatavalid))
      else report_mismatch("av_read/av_write/av_begintransfer/uav_readdatavalid",
         32'($sampled({av_read, av_write, av_begintransfer, uav_readdatavalid})), 32'h0);
   assert property (@(posedge clk) (!reset && was_reset) |-> uav_waitrequest)
      else report_mismatch("uav_waitrequest", 32'($sampled(uav_waitrequest)), 32'h1);
   assert property (@(posedge clk) disable iff (reset) request |-> av_address == req_word)
      else report_mismatch("av_address", 32'($sampled(av_address)), 32'($sampled(req_word)));
   assert property (@(posedge clk) disable iff (reset) request |-> av_byteenable == uav_byteenable)
      else report_mismatch("av_byteenable", 32'($sampled(av_byteenable)),
         32'($sampled(uav_byteenable)));
   assert property (@(posedge clk) disable iff (reset)
         request |-> av_writebyteenable == (uav_byteenable & {4{uav_write}}))
      else report_mismatch("av_writebyteenable", 32'($sampled(av_writebyteenable)),
         32'($sampled(uav_byteenable & {4{uav_write}})));
   assert property (@(posedge clk) disable iff (reset) uav_write |-> av_writedata == uav_writedata)
      else report_mismatch("av_writedata", $sampled(av_writedata), $sampled(uav_writedata));
   assert property (@(posedge clk) disable iff (reset) uav_write |-> av_write ==
         (access_cycle >= SETUP_CYCLES && access_cycle <= SETUP_CYCLES + WRITE_WAIT_CYCLES))
      else report_mismatch("av_write", 32'($sampled(av_write)), 32'($sampled(
         access_cycle >= SETUP_CYCLES && access_cycle <= SETUP_CYCLES + WRITE_WAIT_CYCLES)));
   assert property (@(posedge clk) disable iff (reset)
         uav_write |-> uav_waitrequest == (access_cycle != WRITE_ACCEPT))
      else report_mismatch("uav_waitrequest", 32'($sampled(uav_waitrequest)),
         32'($sampled(access_cycle != WRITE_ACCEPT)));
   assert property (@(posedge clk) disable iff (reset)
         uav_read |-> av_read == (access_cycle >= SETUP_CYCLES))
      else report_mismatch("av_read", 32'($sampled(av_read)),
         32'($sampled(access_cycle >= SETUP_CYCLES)));
   assert property (@(posedge clk) disable iff (reset)
         uav_read |-> uav_waitrequest == (access_cycle != READ_ACCEPT))
      else report_mismatch("uav_waitrequest", 32'($sampled(uav_waitrequest)),
         32'($sampled(access_cycle != READ_ACCEPT)));
   assert property (@(posedge clk) disable iff (reset)
         av_begintransfer == (request && access_cycle == 0))
      else report_mismatch("av_begintransfer", 32'($sampled(av_begintransfer)),
         32'($sampled(request && access_cycle == 0)));
   assert property (@(posedge clk) disable iff (reset)
         uav_readdatavalid == exp_valid[VALID_DEPTH-1])
      else report_mismatch("uav_readdatavalid", 32'($sampled(uav_readdatavalid)),
         32'($sampled(exp_valid[VALID_DEPTH-1])));
   assert property (@(posedge clk) disable iff (reset)
         exp_valid[VALID_DEPTH-1] |-> uav_readdata == exp_data[VALID_DEPTH-1])
      else report_mismatch("uav_readdata", $sampled(uav_readdata),
         $sampled(exp_data[VALID_DEPTH-1]));

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------

   // holds the request until the accept cycle
   task automatic run_access(input logic is_write, input translator_pkg::byte_addr_t addr,
         input translator_pkg::data_t wdata, input translator_pkg::byteen_t be);
      @(posedge clk);
      uav_read <= ~is_write;
      uav_write <= is_write;
      uav_address <= addr;
      uav_writedata <= wdata;
      uav_byteenable <= be;
      do begin
         @(negedge clk);
      end while (uav_waitrequest);
   endtask

   task automatic go_idle(input int cycles);
      @(posedge clk);
      uav_read <= 1'b0;
      uav_write <= 1'b0;
      repeat (cycles) @(posedge clk);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      test_count++;
      $display("test %0d, %s: %0d check failures", test_count, name, error_count - errors_before);
   endtask

   initial begin
      int errors_before;
      uav_address = '0;
      uav_writedata = '0;
      uav_byteenable = '0;
      uav_read = 1'b0;
      uav_write = 1'b0;
      lfsr_state = 32'ha28b_e2b4;
      error_count = 0;
      test_count = 0;

      @(negedge reset);
      repeat (2) @(posedge clk);
      finish_test("reset state", 0);

      // back-to-back writes, timing and enables
      errors_before = error_count;
      for (int i = 0; i < 8; i++) begin
         used_addr[i] = random_bits(32);
         run_access(1'b1, used_addr[i], random_bits(32),
                    translator_pkg::byteen_t'(random_bits(4)));
      end
      go_idle(4);
      finish_test("write timing", errors_before);

      errors_before = error_count;
      for (int i = 0; i < 8; i++) begin
         run_access(1'b0, random_bits(32), '0, translator_pkg::byteen_t'(random_bits(4)));
      end
      go_idle(READ_LATENCY + 2);
      finish_test("read timing and data", errors_before);

      // alternating reads and writes with no idle cycle between
      errors_before = error_count;
      for (int i = 0; i < 6; i++) begin
         run_access(i[0], random_bits(32), random_bits(32),
                    translator_pkg::byteen_t'(random_bits(4)));
      end
      go_idle(READ_LATENCY + 2);
      finish_test("begin-transfer", errors_before);

      errors_before = error_count;
      for (int i = 0; i < 8; i++) begin
         run_access(1'b1, used_addr[i], random_bits(32),
                    translator_pkg::byteen_t'(random_bits(4)));
      end
      for (int i = 0; i < 8; i++) begin
         run_access(1'b0, used_addr[i], '0, 4'hf);
      end
      go_idle(READ_LATENCY + 2);
      finish_test("write then read back", errors_before);

      $display("tests run: %0d, failed checks: %0d", test_count, error_count);
      if (error_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // run limit
   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
source/translator_pkg.sv
source/request_adapter.sv
source/wait_state_generator.sv
source/read_latency_tracker.sv
source/slave_translator.sv
verif/tb_clock_gen.sv
verif/slave_translator_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the slave_translator testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=slave_translator_tb
OBJ_DIR=obj_dir
SIM_EXE=sim_$TOP

verilator --binary --timing --assert \
   --top-module "$TOP" --Mdir "$OBJ_DIR" -o "$SIM_EXE" \
   -f src.f
if [ $? -ne 0 ]; then
   echo "compile step failed"
   exit 1
fi

sim_output=$("./$OBJ_DIR/$SIM_EXE")
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

# the run counts as good only if the pass line was printed
if echo "$sim_output" | grep -qx "Verification passed"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
